/* hdl/tx_pkg.sv */
`default_nettype none

package tx_pkg;

    // Defaults for the top-level parameters.
    localparam int LANES_DEF   = 4;  // Lane count equals port count.
    localparam int DATA_W_DEF  = 16;
    localparam int LEN_MAX_DEF = 8;  // Max body words per packet.
    localparam int DEPTH_DEF   = 4;  // Park slots per lane.

    // Top nibble of a header word; low bits hold the body length.
    localparam logic [3:0] HDR_TAG = 4'hA;

    typedef enum logic [1:0] {
        TX_IDLE,    // Waiting for a header.
        TX_STREAM,  // Body words in flight.
        TX_CLOSE    // Signal done.
    } tx_state_e;

endpackage

`default_nettype wire

/* hdl/flit_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface flit_if #(
    parameter int LANES  = tx_pkg::LANES_DEF,
    parameter int DATA_W = tx_pkg::DATA_W_DEF
);
    localparam int SEL_W = $clog2(LANES);

    logic              valid;  // Word present this cycle.
    logic [SEL_W-1:0]  lane;
    logic [SEL_W-1:0]  dst;    // Destination port.
    logic [DATA_W-1:0] data;

    modport src (output valid, lane, dst, data);
    modport snk (input valid, lane, dst, data);

endinterface

`default_nettype wire

/* hdl/header_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module header_decoder #(
    parameter int DATA_W  = tx_pkg::DATA_W_DEF,
    parameter int LEN_MAX = tx_pkg::LEN_MAX_DEF
) (
    input  logic [DATA_W-1:0]              data,
    input  logic [DATA_W-1:0]              park_data,
    input  logic                           sel,
    output logic                           is_header,
    output logic [$clog2(LEN_MAX+1)-1:0]   hdr_len
);
    import tx_pkg::*;

    localparam int LEN_W = $clog2(LEN_MAX + 1);

    logic [DATA_W-1:0] word;
    logic [3:0]        tag;

    assign word    = sel ? park_data : data;  // Parked head when selected.
    assign tag     = word[DATA_W-1 -: 4];
    assign hdr_len = word[LEN_W-1:0];

    // Zero or oversize length is not a header.
    assign is_header = (tag == HDR_TAG) && (hdr_len != '0) &&
                       (hdr_len <= LEN_W'(LEN_MAX));

endmodule

`default_nettype wire

/* hdl/park_list.sv */
`timescale 1ns/1ps
`default_nettype none

module park_list #(
    parameter int LANES  = tx_pkg::LANES_DEF,
    parameter int DATA_W = tx_pkg::DATA_W_DEF,
    parameter int DEPTH  = tx_pkg::DEPTH_DEF
) (
    input  logic                     clk,
    input  logic                     rst_n,
    flit_if.snk                      wr_bus,
    input  logic                     park_wr,
    input  logic [$clog2(LANES)-1:0] rd_lane,
    input  logic                     park_rd,
    flit_if.src                      head,
    output logic [LANES-1:0]         full
);
    localparam int SEL_W = $clog2(LANES);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [SEL_W-1:0]  dst_mem  [LANES][DEPTH];
    logic [DATA_W-1:0] data_mem [LANES][DEPTH];
    logic [PTR_W-1:0]  wr_ptr   [LANES];
    logic [PTR_W-1:0]  rd_ptr   [LANES];
    logic [CNT_W-1:0]  cnt      [LANES];
    logic [LANES-1:0]  wr_hit;
    logic [LANES-1:0]  rd_hit;
    logic              wr_en;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign wr_en = park_wr && wr_bus.valid;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            wr_hit[i] = wr_en && (wr_bus.lane == SEL_W'(i));
            rd_hit[i] = park_rd && (rd_lane == SEL_W'(i));
            full[i]   = (cnt[i] == CNT_W'(DEPTH));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < LANES; i++) begin
                wr_ptr[i] <= '0;
                rd_ptr[i] <= '0;
                cnt[i]    <= '0;
            end
        end else begin
            for (int i = 0; i < LANES; i++) begin
                if (wr_hit[i])
                    wr_ptr[i] <= next_ptr(wr_ptr[i]);
                if (rd_hit[i])
                    rd_ptr[i] <= next_ptr(rd_ptr[i]);
                if (wr_hit[i] && !rd_hit[i])
                    cnt[i] <= cnt[i] + 1'b1;
                else if (rd_hit[i] && !wr_hit[i])
                    cnt[i] <= cnt[i] - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            dst_mem[wr_bus.lane][wr_ptr[wr_bus.lane]]  <= wr_bus.dst;
            data_mem[wr_bus.lane][wr_ptr[wr_bus.lane]] <= wr_bus.data;
        end
    end

    // Head of the lane the controller is looking at.
    assign head.valid = (cnt[rd_lane] != '0);
    assign head.lane  = rd_lane;
    assign head.dst   = dst_mem[rd_lane][rd_ptr[rd_lane]];
    assign head.data  = data_mem[rd_lane][rd_ptr[rd_lane]];

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> !full[wr_bus.lane])
        else $error("park_list: write to full lane %0d", wr_bus.lane);

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        park_rd |-> (cnt[rd_lane] != '0))
        else $error("park_list: read from empty lane %0d", rd_lane);

endmodule

`default_nettype wire

/* hdl/burst_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module burst_tracker #(
    parameter int LANES   = tx_pkg::LANES_DEF,
    parameter int LEN_MAX = tx_pkg::LEN_MAX_DEF,
    parameter int PORT_ID = 0
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         trk_load,
    input  logic                         trk_step,
    input  logic                         trk_clear,
    input  logic [$clog2(LEN_MAX+1)-1:0] hdr_len,
    output logic [$clog2(LANES)-1:0]     expect_lane,
    output logic                         remaining_zero
);
    localparam int SEL_W = $clog2(LANES);
    localparam int LEN_W = $clog2(LEN_MAX + 1);
    localparam logic [SEL_W-1:0] HOME = SEL_W'(PORT_ID);

    logic [LEN_W-1:0] remaining;
    logic [SEL_W-1:0] lane_next;

    assign lane_next = (expect_lane == SEL_W'(LANES - 1)) ? '0 : expect_lane + 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            expect_lane <= HOME;
            remaining   <= '0;
        end else if (trk_clear) begin
            expect_lane <= HOME;
            remaining   <= '0;
        end else if (trk_load) begin
            remaining   <= hdr_len;  // Stripe 1 follows the header.
            expect_lane <= lane_next;
        end else if (trk_step) begin
            remaining   <= remaining - 1'b1;
            expect_lane <= lane_next;
        end
    end

    assign remaining_zero = (remaining == '0);

    a_step_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        trk_step |-> !remaining_zero)
        else $error("burst_tracker: step with no body words left");

endmodule

`default_nettype wire

/* hdl/tx_out_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_out_stage #(
    parameter int LANES   = tx_pkg::LANES_DEF,
    parameter int DATA_W  = tx_pkg::DATA_W_DEF,
    parameter int PORT_ID = 0
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     keep,
    flit_if.snk                      in_bus,
    flit_if.snk                      park_bus,
    input  logic                     out_src,
    input  logic                     out_fire,
    input  logic                     done_pulse,
    input  logic [LANES-1:0]         done_in,
    output logic                     valid_out,
    output logic [$clog2(LANES)-1:0] lane_out,
    output logic [$clog2(LANES)-1:0] dst_out,
    output logic [DATA_W-1:0]        data_out,
    output logic [LANES-1:0]         done_out
);
    logic [LANES-1:0] done_merge;

    always_comb begin
        done_merge          = done_in;
        done_merge[PORT_ID] = done_pulse;  // Own slot of the chain.
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
            done_out  <= '0;
        end else if (!keep) begin
            valid_out <= out_fire;
            done_out  <= done_merge;
        end
    end

    always_ff @(posedge clk) begin
        if (!keep) begin
            lane_out <= out_src ? park_bus.lane : in_bus.lane;
            dst_out  <= out_src ? park_bus.dst  : in_bus.dst;
            data_out <= out_src ? park_bus.data : in_bus.data;
        end
    end

endmodule

`default_nettype wire

/* hdl/tx_order_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_order_ctrl #(
    parameter int LANES   = tx_pkg::LANES_DEF,
    parameter int PORT_ID = 0
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     keep,
    flit_if.snk                      in_bus,
    flit_if.snk                      park_bus,
    input  logic                     is_header,
    input  logic [$clog2(LANES)-1:0] expect_lane,
    input  logic                     remaining_zero,
    output logic                     dec_sel,
    output logic                     park_wr,
    output logic                     park_rd,
    output logic [$clog2(LANES)-1:0] rd_lane,
    output logic                     out_src,
    output logic                     out_fire,
    output logic                     done_pulse,
    output logic                     trk_load,
    output logic                     trk_step,
    output logic                     trk_clear
);
    import tx_pkg::*;

    localparam int SEL_W = $clog2(LANES);
    localparam logic [SEL_W-1:0] HOME = SEL_W'(PORT_ID);

    tx_state_e state;
    tx_state_e state_n;
    logic      own_in;
    logic      foreign_in;

    assign own_in     = in_bus.valid && (in_bus.dst == HOME);
    assign foreign_in = in_bus.valid && (in_bus.dst != HOME);
    assign rd_lane    = (state == TX_STREAM) ? expect_lane : HOME;
    assign dec_sel    = park_bus.valid;  // Parked head has priority.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= TX_IDLE;
        else
            state <= state_n;
    end

    always_comb begin
        state_n    = state;
        park_wr    = 1'b0;
        park_rd    = 1'b0;
        out_src    = 1'b0;
        out_fire   = 1'b0;
        done_pulse = 1'b0;
        trk_load   = 1'b0;
        trk_step   = 1'b0;
        trk_clear  = 1'b0;

        if (!keep) begin
            // Other ports' words own the output this cycle.
            if (foreign_in)
                out_fire = 1'b1;

            case (state)
                TX_IDLE: begin
                    if (!foreign_in && park_bus.valid && is_header) begin
                        park_rd  = 1'b1;
                        out_src  = 1'b1;
                        out_fire = 1'b1;
                        trk_load = 1'b1;
                        park_wr  = own_in;  // Input loses to the release.
                        state_n  = TX_STREAM;
                    end else if (own_in && !park_bus.valid && is_header &&
                                 (in_bus.lane == HOME)) begin
                        out_fire = 1'b1;
                        trk_load = 1'b1;
                        state_n  = TX_STREAM;
                    end else begin
                        park_wr = own_in;
                    end
                end

                TX_STREAM: begin
                    if (remaining_zero) begin
                        park_wr = own_in;
                        state_n = TX_CLOSE;
                    end else if (!foreign_in && park_bus.valid) begin
                        park_rd  = 1'b1;
                        out_src  = 1'b1;
                        out_fire = 1'b1;
                        trk_step = 1'b1;
                        park_wr  = own_in;
                    end else if (own_in && (in_bus.lane == expect_lane)) begin
                        out_fire = 1'b1;
                        trk_step = 1'b1;
                    end else begin
                        park_wr = own_in;  // Early stripe.
                    end
                end

                TX_CLOSE: begin
                    done_pulse = 1'b1;
                    trk_clear  = 1'b1;
                    park_wr    = own_in;
                    state_n    = TX_IDLE;
                end

                default: state_n = TX_IDLE;
            endcase
        end
    end

    // Upstream stays quiet under keep.
    a_keep_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        keep |-> !in_bus.valid)
        else $error("tx_order_ctrl: input word while keep is high");

endmodule

`default_nettype wire

/* hdl/tx_manage_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_manage_top #(
    parameter int LANES   = tx_pkg::LANES_DEF,
    parameter int DATA_W  = tx_pkg::DATA_W_DEF,
    parameter int LEN_MAX = tx_pkg::LEN_MAX_DEF,
    parameter int DEPTH   = tx_pkg::DEPTH_DEF,
    parameter int PORT_ID = 0
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     keep,
    input  logic                     valid_in,
    input  logic [$clog2(LANES)-1:0] lane_in,
    input  logic [$clog2(LANES)-1:0] dst_in,
    input  logic [DATA_W-1:0]        data_in,
    input  logic [LANES-1:0]         done_in,
    output logic                     valid_out,
    output logic [$clog2(LANES)-1:0] lane_out,
    output logic [$clog2(LANES)-1:0] dst_out,
    output logic [DATA_W-1:0]        data_out,
    output logic [LANES-1:0]         done_out
);
    localparam int SEL_W = $clog2(LANES);
    localparam int LEN_W = $clog2(LEN_MAX + 1);

    flit_if #(.LANES(LANES), .DATA_W(DATA_W)) in_flit ();
    flit_if #(.LANES(LANES), .DATA_W(DATA_W)) park_flit ();

    logic             dec_sel;
    logic             is_header;
    logic [LEN_W-1:0] hdr_len;
    logic             park_wr;
    logic             park_rd;
    logic [SEL_W-1:0] rd_lane;
    logic             out_src;
    logic             out_fire;
    logic             done_pulse;
    logic             trk_load;
    logic             trk_step;
    logic             trk_clear;
    logic [SEL_W-1:0] expect_lane;
    logic             remaining_zero;

    assign in_flit.valid = valid_in;
    assign in_flit.lane  = lane_in;
    assign in_flit.dst   = dst_in;
    assign in_flit.data  = data_in;

    header_decoder #(.DATA_W(DATA_W), .LEN_MAX(LEN_MAX)) u_header_decoder (
        .data      (in_flit.data),
        .park_data (park_flit.data),
        .sel       (dec_sel),
        .is_header (is_header),
        .hdr_len   (hdr_len)
    );

    park_list #(.LANES(LANES), .DATA_W(DATA_W), .DEPTH(DEPTH)) u_park_list (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_bus  (in_flit.snk),
        .park_wr (park_wr),
        .rd_lane (rd_lane),
        .park_rd (park_rd),
        .head    (park_flit.src),
        .full    ()
    );

    burst_tracker #(.LANES(LANES), .LEN_MAX(LEN_MAX), .PORT_ID(PORT_ID)) u_burst_tracker (
        .clk            (clk),
        .rst_n          (rst_n),
        .trk_load       (trk_load),
        .trk_step       (trk_step),
        .trk_clear      (trk_clear),
        .hdr_len        (hdr_len),
        .expect_lane    (expect_lane),
        .remaining_zero (remaining_zero)
    );

    tx_order_ctrl #(.LANES(LANES), .PORT_ID(PORT_ID)) u_tx_order_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .keep           (keep),
        .in_bus         (in_flit.snk),
        .park_bus       (park_flit.snk),
        .is_header      (is_header),
        .expect_lane    (expect_lane),
        .remaining_zero (remaining_zero),
        .dec_sel        (dec_sel),
        .park_wr        (park_wr),
        .park_rd        (park_rd),
        .rd_lane        (rd_lane),
        .out_src        (out_src),
        .out_fire       (out_fire),
        .done_pulse     (done_pulse),
        .trk_load       (trk_load),
        .trk_step       (trk_step),
        .trk_clear      (trk_clear)
    );

    tx_out_stage #(.LANES(LANES), .DATA_W(DATA_W), .PORT_ID(PORT_ID)) u_tx_out_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .keep       (keep),
        .in_bus     (in_flit.snk),
        .park_bus   (park_flit.snk),
        .out_src    (out_src),
        .out_fire   (out_fire),
        .done_pulse (done_pulse),
        .done_in    (done_in),
        .valid_out  (valid_out),
        .lane_out   (lane_out),
        .dst_out    (dst_out),
        .data_out   (data_out),
        .done_out   (done_out)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

/* testbench/tb_tx_manage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_tx_manage;
    import tx_pkg::*;

    localparam int LANES   = 4;
    localparam int DATA_W  = 16;
    localparam int PORT_ID = 1;
    localparam int SEL_W   = $clog2(LANES);
    localparam int WORD_W  = 2 * SEL_W + DATA_W;
    localparam logic [SEL_W-1:0] OWN = SEL_W'(PORT_ID);
    // Reset, pass, in order, out of order, keep, chain, tail.
    localparam int TEST_CYCLES = 4 + 10 + 10 + 12 + 16 + 12 + 2;
    localparam int MAX_CYCLES  = TEST_CYCLES + 100;

    logic              clk;
    logic              rst_n;
    logic              keep;
    logic              valid_in;
    logic [SEL_W-1:0]  lane_in;
    logic [SEL_W-1:0]  dst_in;
    logic [DATA_W-1:0] data_in;
    logic [LANES-1:0]  done_in;
    logic              valid_out;
    logic [SEL_W-1:0]  lane_out;
    logic [SEL_W-1:0]  dst_out;
    logic [DATA_W-1:0] data_out;
    logic [LANES-1:0]  done_out;

    logic [WORD_W-1:0] out_q[$];  // Words seen on the output.
    int   pushed   = 0;
    int   taken    = 0;
    int   done_cnt = 0;
    int   word_cyc = 0;
    int   done_cyc = 0;
    int   neg_cyc  = 0;
    int   cyc      = 0;
    logic loaded   = 1'b0;  // Output register took a new value at the last edge.

    tb_clock #(.PERIOD_NS(40)) u_clock (.clk(clk));

    tx_manage_top #(
        .LANES(LANES), .DATA_W(DATA_W), .LEN_MAX(LEN_MAX_DEF),
        .DEPTH(DEPTH_DEF), .PORT_ID(PORT_ID)
    ) u_tx_manage_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .keep      (keep),
        .valid_in  (valid_in),
        .lane_in   (lane_in),
        .dst_in    (dst_in),
        .data_in   (data_in),
        .done_in   (done_in),
        .valid_out (valid_out),
        .lane_out  (lane_out),
        .dst_out   (dst_out),
        .data_out  (data_out),
        .done_out  (done_out)
    );

    always @(posedge clk) begin
        cyc    <= cyc + 1;
        loaded <= !keep;
        if (cyc >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles.", MAX_CYCLES);
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    // Output monitor.
    always @(negedge clk) begin
        neg_cyc++;
        if (rst_n && loaded && valid_out) begin
            out_q.push_back({dst_out, lane_out, data_out});
            word_cyc = neg_cyc;
            pushed++;
        end
        if (rst_n && loaded && done_out[PORT_ID]) begin
            done_cyc = neg_cyc;
            done_cnt++;
        end
    end

    function automatic logic [SEL_W-1:0] stripe(input int k);
        return SEL_W'((PORT_ID + k) % LANES);  // Lane of body word k.
    endfunction

    function automatic logic [DATA_W-1:0] make_header(input int len);
        logic [DATA_W-1:0] d;
        d = DATA_W'($urandom);
        d[DATA_W-1 -: 4] = HDR_TAG;
        d[3:0] = 4'(len);
        return d;
    endfunction

    task automatic send_word(input logic [SEL_W-1:0] lane, input logic [SEL_W-1:0] dst,
                             input logic [DATA_W-1:0] data);
        @(posedge clk);
        valid_in <= 1'b1;
        lane_in  <= lane;
        dst_in   <= dst;
        data_in  <= data;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            valid_in <= 1'b0;
        end
    endtask

    task automatic check_word(input string test,
                              input logic [SEL_W-1:0] exp_dst, input logic [SEL_W-1:0] exp_lane,
                              input logic [DATA_W-1:0] exp_data,
                              input logic [SEL_W-1:0] act_dst, input logic [SEL_W-1:0] act_lane,
                              input logic [DATA_W-1:0] act_data);
        if (act_dst !== exp_dst || act_lane !== exp_lane || act_data !== exp_data) begin
            $display("** Error [%s] word: expected dst %0d lane %0d data %h,",
                     test, exp_dst, exp_lane, exp_data,
                     " actual dst %0d lane %0d data %h", act_dst, act_lane, act_data);
            $display("SOME TESTS FAILED");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_done(input string test, input logic [LANES-1:0] exp,
                              input logic [LANES-1:0] act);
        if (act !== exp) begin
            $display("** Error [%s] done_out: expected %b, actual %b", test, exp, act);
            $display("SOME TESTS FAILED");
            $fatal(1, "done vector mismatch");
        end
    endtask

    task automatic check_flag(input string test, input string what, input logic exp,
                              input logic act);
        if (act !== exp) begin
            $display("** Error [%s] %s: expected %b, actual %b", test, what, exp, act);
            $display("SOME TESTS FAILED");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic check_count(input string test, input string what, input int exp,
                               input int act);
        if (act != exp) begin
            $display("** Error [%s] %s: expected %0d, actual %0d", test, what, exp, act);
            $display("SOME TESTS FAILED");
            $fatal(1, "count mismatch");
        end
    endtask

    task automatic expect_word(input string test, input logic [SEL_W-1:0] dst,
                               input logic [SEL_W-1:0] lane, input logic [DATA_W-1:0] data);
        logic [WORD_W-1:0] w;
        wait (pushed > taken);
        w = out_q.pop_front();
        taken++;
        check_word(test, dst, lane, data,
                   w[WORD_W-1 -: SEL_W], w[DATA_W +: SEL_W], w[DATA_W-1:0]);
    endtask

    // One pulse, two cycles after the last word, then low again.
    task automatic expect_done(input string test, input int base);
        wait (done_cnt > base);
        check_count(test, "cycles from last word to done", 2, done_cyc - word_cyc);
        @(negedge clk);
        check_done(test, '0, done_out);
    endtask

    task automatic test_reset();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag("reset", "valid_out", 1'b0, valid_out);
        check_done("reset", '0, done_out);
    endtask

    task automatic test_pass_through();
        logic [SEL_W-1:0]  dst;
        logic [SEL_W-1:0]  lane;
        logic [DATA_W-1:0] d;
        int                base;
        base = done_cnt;
        for (int i = 0; i < 3; i++) begin
            dst  = SEL_W'((i == 0) ? 0 : i + 1);  // Ports 0, 2, 3.
            lane = SEL_W'(i + 1);
            d    = DATA_W'($urandom);
            send_word(lane, dst, d);
            idle(1);
            @(negedge clk);
            check_flag("pass_through", "valid_out", 1'b1, valid_out);
            check_word("pass_through", dst, lane, d, dst_out, lane_out, data_out);
            check_flag("pass_through", "own done bit", 1'b0, done_out[PORT_ID]);
            expect_word("pass_through", dst, lane, d);
        end
        idle(3);
        check_count("pass_through", "done pulses", base, done_cnt);
    endtask

    task automatic test_in_order();
        logic [DATA_W-1:0] hdr;
        logic [DATA_W-1:0] body [3];
        int                base;
        base = done_cnt;
        hdr  = make_header(3);
        foreach (body[k])
            body[k] = DATA_W'($urandom);
        send_word(OWN, OWN, hdr);
        for (int k = 0; k < 3; k++)
            send_word(stripe(k + 1), OWN, body[k]);
        idle(1);
        expect_word("in_order", OWN, OWN, hdr);
        for (int k = 0; k < 3; k++)
            expect_word("in_order", OWN, stripe(k + 1), body[k]);
        expect_done("in_order", base);
    endtask

    task automatic test_out_of_order();
        logic [DATA_W-1:0] hdr;
        logic [DATA_W-1:0] body [3];
        int                base;
        base = done_cnt;
        hdr  = make_header(3);
        foreach (body[k])
            body[k] = DATA_W'($urandom);
        send_word(stripe(2), OWN, body[1]);  // Early stripes.
        send_word(stripe(3), OWN, body[2]);
        send_word(OWN, OWN, hdr);
        send_word(stripe(1), OWN, body[0]);
        idle(1);
        expect_word("out_of_order", OWN, OWN, hdr);
        for (int k = 0; k < 3; k++)
            expect_word("out_of_order", OWN, stripe(k + 1), body[k]);
        expect_done("out_of_order", base);
    endtask

    task automatic test_keep();
        logic [DATA_W-1:0] hdr;
        logic [DATA_W-1:0] body [3];
        int                base;
        base = done_cnt;
        hdr  = make_header(3);
        foreach (body[k])
            body[k] = DATA_W'($urandom);
        send_word(stripe(2), OWN, body[1]);  // Waits in the park list.
        send_word(OWN, OWN, hdr);
        send_word(stripe(1), OWN, body[0]);
        @(posedge clk);
        valid_in <= 1'b0;
        keep     <= 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_flag("keep", "valid_out", 1'b1, valid_out);
            check_word("keep", OWN, stripe(1), body[0], dst_out, lane_out, data_out);
        end
        @(posedge clk);
        keep <= 1'b0;
        send_word(stripe(3), OWN, body[2]);
        idle(1);
        expect_word("keep", OWN, OWN, hdr);
        for (int k = 0; k < 3; k++)
            expect_word("keep", OWN, stripe(k + 1), body[k]);
        expect_done("keep", base);
    endtask

    task automatic test_done_chain();
        logic [LANES-1:0] pattern [4];
        logic [LANES-1:0] expected;
        pattern = '{4'b0001, 4'b0100, 4'b1000, 4'b1111};
        foreach (pattern[k]) begin
            expected          = pattern[k];
            expected[PORT_ID] = 1'b0;  // Own slot follows the FSM only.
            @(posedge clk);
            done_in <= pattern[k];
            @(posedge clk);
            done_in <= '0;
            @(negedge clk);
            check_done("done_chain", expected, done_out);
            @(negedge clk);
            check_done("done_chain", '0, done_out);
        end
    endtask

    initial begin
        void'($urandom(46));
        rst_n    = 1'b0;
        keep     = 1'b0;
        valid_in = 1'b0;
        lane_in  = '0;
        dst_in   = '0;
        data_in  = '0;
        done_in  = '0;
        test_reset();
        test_pass_through();
        test_in_order();
        test_out_of_order();
        test_keep();
        test_done_chain();
        idle(2);
        check_count("final", "own done pulses", 3, done_cnt);  // One per packet.
        check_count("final", "output words", taken, pushed);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
hdl/tx_pkg.sv
hdl/flit_if.sv
hdl/header_decoder.sv
hdl/park_list.sv
hdl/burst_tracker.sv
hdl/tx_out_stage.sv
hdl/tx_order_ctrl.sv
hdl/tx_manage_top.sv
testbench/tb_clock.sv
testbench/tb_tx_manage.sv
